// File: verilog.f
+incdir+rtl
rtl/owt_pkg.sv
rtl/owt_sym_if.sv
rtl/owt_mcst_decoder.sv
rtl/owt_crc8.sv
rtl/owt_frame_rx.sv
rtl/owt_link_health.sv
rtl/owt_rx_top.sv
tb/owt_rx_asserts.sv
tb/owt_rx_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= owt_rx_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/owt_rx_tb.sv
// one-wire receiver testbench
`timescale 1ns/1ps
`include "owt_macros.svh"

module owt_rx_tb;

    localparam int N_FRAMES = 40;
    // a timeout frame takes about 2048 + 64 cycles plus its head
    localparam int CYC_LIMIT = N_FRAMES * 3000;
    localparam logic [7:0] ADC_CMD = {1'b0, `OWT_ADC_CODE};

    logic        i_clk;
    logic        i_rst_n;
    logic        i_owt_line;
    logic        i_comerr_mode;
    logic [3:0]  i_comerr_cfg;
    logic        o_rx_ack;
    logic        o_rx_status;
    logic        o_com_err;
    logic [7:0]  o_rx_cmd;
    logic [15:0] o_rx_data;

    bit          tx_bits[$];
    int          cyc_cnt = 0;
    int          ack_cnt = 0;
    logic        cap_status;
    logic        cap_com_err;
    logic [7:0]  cap_cmd;
    logic [15:0] cap_data;

    owt_rx_top dut (.*);

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= CYC_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYC_LIMIT);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    end

    // capture every acknowledge at the falling edge
    always @(negedge i_clk) begin
        if (o_rx_ack) begin
            ack_cnt     <= ack_cnt + 1;
            cap_status  <= o_rx_status;
            cap_com_err <= o_com_err;
            cap_cmd     <= o_rx_cmd;
            cap_data    <= o_rx_data;
        end
        if (dut.u_asserts.any_fail) begin
            $display("a bound assertion on the DUT outputs failed");
            $display("STATUS: FAIL");
            $fatal(1);
        end
    end

    // ========================================
    // model helpers
    // ========================================
    function automatic int add_step(input logic [1:0] sel);
        case (sel)
            2'd0:    return `OWT_ERR_ADD_0;
            2'd1:    return `OWT_ERR_ADD_1;
            2'd2:    return `OWT_ERR_ADD_2;
            default: return `OWT_ERR_ADD_3;
        endcase
    endfunction

    function automatic int sub_step(input logic [1:0] sel);
        case (sel)
            2'd0:    return `OWT_ERR_SUB_0;
            2'd1:    return `OWT_ERR_SUB_1;
            2'd2:    return `OWT_ERR_SUB_2;
            default: return `OWT_ERR_SUB_3;
        endcase
    endfunction

    // long division of the message times x^8 by the generator
    function automatic logic [7:0] crc_model(input int n_msg);
        logic [8:0] rem;
        rem = '0;
        for (int i = 0; i < n_msg + `OWT_CRC_BITS; i++) begin
            rem = {rem[7:0], (i < n_msg) ? tx_bits[i] : 1'b0};
            if (rem[8]) begin
                rem = rem ^ {1'b1, `OWT_CRC_POLY};
            end
        end
        return rem[7:0];
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
        if (exp_val !== act_val) begin
            $display("Error %s: expected 0x%0h, actual 0x%0h", name, exp_val, act_val);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    task automatic hold_level(input logic lvl, input int cycles);
        i_owt_line <= lvl;
        repeat (cycles) @(posedge i_clk);
    endtask

    task automatic append_field(input logic [15:0] val, input int width);
        for (int i = width - 1; i >= 0; i--) begin
            tx_bits.push_back(val[i]);
        end
    endtask

    // head, tail, then n_send manchester bits, line left low
    task automatic send_frame(input int t, input int n_send);
        repeat (4) begin
            hold_level(1'b1, t);
            hold_level(1'b0, t);
        end
        hold_level(1'b1, 2 * t);
        hold_level(1'b0, t);
        for (int i = 0; i < n_send; i++) begin
            hold_level(tx_bits[i], t);
            hold_level(!tx_bits[i], t);
        end
        i_owt_line <= 1'b0;
    endtask

    // ========================================
    // stimulus and checks
    // ========================================
    initial begin
        int          t;
        int          kind;
        int          n_msg;
        int          err_model;
        logic [31:0] rnd;
        logic [7:0]  cmd;
        logic [15:0] data;
        logic [7:0]  crc;
        logic [7:0]  exp_cmd;
        logic [15:0] exp_data;
        logic        is_adc;
        logic        bad;
        logic        exp_flag;
        string       tag;

        i_rst_n       = 1'b0;
        i_owt_line    = 1'b0;
        i_comerr_mode = 1'b0;
        i_comerr_cfg  = 4'h0;
        void'($urandom(32'h5855));
        exp_cmd   = '0;
        exp_data  = '0;
        err_model = `OWT_ERR_MAX;
        repeat (2) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(negedge i_clk);
        check_val("reset ack", 32'd0, 32'(o_rx_ack));
        check_val("reset status", 32'd0, 32'(o_rx_status));
        check_val("reset com_err", 32'd1, 32'(o_com_err));
        @(posedge i_clk);

        for (int k = 0; k < N_FRAMES; k++) begin
            tag = $sformatf("frame %0d", k);
            // configuration moves only while the line idles
            rnd = $urandom;
            i_comerr_cfg  <= rnd[3:0];
            i_comerr_mode <= rnd[4];
            hold_level(1'b0, 16);

            // kind 2 and 4 force adc, 3 flips a crc bit, 5 is cut after the command
            t    = 6 + int'($urandom % 7);
            kind = k % 6;
            rnd  = $urandom;
            cmd  = (kind == 2 || kind == 4) ? ADC_CMD : rnd[7:0];
            is_adc = (cmd == ADC_CMD);
            rnd  = $urandom;
            data = is_adc ? {4'h0, rnd[11:0]} : {8'h00, rnd[7:0]};
            tx_bits.delete();
            append_field({8'h00, cmd}, `OWT_CMD_BITS);
            append_field(data, is_adc ? `OWT_ADC_BITS : `OWT_NML_BITS);
            n_msg = tx_bits.size();
            crc   = crc_model(n_msg);
            if (kind == 3) begin
                crc[rnd[14:12]] = ~crc[rnd[14:12]];
            end
            append_field({8'h00, crc}, `OWT_CRC_BITS);
            bad = (kind == 3) || (kind == 5);
            send_frame(t, (kind == 5) ? `OWT_CMD_BITS : tx_bits.size());

            while (ack_cnt == k) begin
                @(negedge i_clk);
            end

            if (bad) begin
                err_model = err_model + add_step(i_comerr_cfg[3:2]);
                if (err_model > `OWT_ERR_MAX) begin
                    err_model = `OWT_ERR_MAX;
                end
            end else begin
                err_model = err_model - sub_step(i_comerr_cfg[1:0]);
                if (err_model < 0) begin
                    err_model = 0;
                end
                exp_cmd  = cmd;
                exp_data = data;
            end
            exp_flag = i_comerr_mode ? (err_model == 0)
                                     : (err_model >= add_step(i_comerr_cfg[3:2]));

            check_val({tag, " ack count"}, k + 1, ack_cnt);
            check_val({tag, " status"}, 32'(bad), 32'(cap_status));
            check_val({tag, " cmd"}, 32'(exp_cmd), 32'(cap_cmd));
            check_val({tag, " data"}, 32'(exp_data), 32'(cap_data));
            check_val({tag, " com_err"}, 32'(exp_flag), 32'(cap_com_err));
            @(posedge i_clk);
        end

        @(negedge i_clk);
        if (dut.u_asserts.any_fail) begin
            $display("a bound assertion on the DUT outputs failed");
            $display("STATUS: FAIL");
            $fatal(1);
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

// File: tb/owt_rx_asserts.sv
// receiver output assertions
`timescale 1ns/1ps

module owt_rx_asserts (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_rx_ack,
    input logic i_rx_status,
    input logic i_com_err
);

    bit  ack_fail    = 1'b0;
    bit  status_fail = 1'b0;
    bit  flag_fail   = 1'b0;
    wire any_fail    = ack_fail | status_fail | flag_fail;

    // acknowledge is a single-cycle pulse
    ack_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_rx_ack |=> !i_rx_ack)
        else begin
            ack_fail = 1'b1;
            $error("o_rx_ack held for more than one cycle");
        end

    status_with_ack: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_rx_status |-> i_rx_ack)
        else begin
            status_fail = 1'b1;
            $error("o_rx_status high without o_rx_ack");
        end

    // flag only moves together with an acknowledge
    flag_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_rx_ack |-> $stable(i_com_err))
        else begin
            flag_fail = 1'b1;
            $error("o_com_err changed between acknowledges");
        end

endmodule

bind owt_rx_top owt_rx_asserts u_asserts (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_rx_ack    (o_rx_ack),
    .i_rx_status (o_rx_status),
    .i_com_err   (o_com_err)
);

// File: rtl/owt_rx_top.sv
// one-wire command receiver top
`timescale 1ns/1ps
`include "owt_macros.svh"

module owt_rx_top (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_owt_line,
    input  logic                     i_comerr_mode,
    input  logic [3:0]               i_comerr_cfg,
    output logic                     o_rx_ack,
    output logic                     o_rx_status,
    output logic                     o_com_err,
    output logic [`OWT_CMD_BITS-1:0] o_rx_cmd,
    output logic [`OWT_DATA_W-1:0]   o_rx_data
);

    logic frame_done;
    logic frame_bad;

    owt_sym_if sym (
        .i_clk (i_clk)
    );

    owt_mcst_decoder u_decoder (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_line  (i_owt_line),
        .sym     (sym.decoder)
    );

    owt_frame_rx u_frame_rx (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .sym          (sym.frame),
        .o_frame_done (frame_done),
        .o_frame_bad  (frame_bad),
        .o_cmd        (o_rx_cmd),
        .o_data       (o_rx_data)
    );

    owt_link_health u_health (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_frame_done  (frame_done),
        .i_frame_bad   (frame_bad),
        .i_comerr_mode (i_comerr_mode),
        .i_comerr_cfg  (i_comerr_cfg),
        .o_rx_ack      (o_rx_ack),
        .o_rx_status   (o_rx_status),
        .o_com_err     (o_com_err)
    );

endmodule

// File: rtl/owt_link_health.sv
// acknowledge and link health
`timescale 1ns/1ps
`include "owt_macros.svh"

module owt_link_health (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_frame_done,
    input  logic       i_frame_bad,
    input  logic       i_comerr_mode,
    input  logic [3:0] i_comerr_cfg,
    output logic       o_rx_ack,
    output logic       o_rx_status,
    output logic       o_com_err
);

    localparam int DLY_W = $clog2(`OWT_RSP_DLY);
    localparam int ERR_W = $clog2(`OWT_ERR_MAX + 1);

    logic [DLY_W-1:0] dly_cnt;
    logic             dly_on;
    logic             dly_fire;
    logic             ack_good;
    logic [ERR_W-1:0] err_cnt;
    logic [ERR_W-1:0] err_nxt;
    logic [ERR_W-1:0] add_step;
    logic [ERR_W-1:0] sub_step;
    logic [ERR_W:0]   err_sum;
    logic             flag_nxt;

    assign ack_good = i_frame_done && !i_frame_bad;
    assign dly_fire = dly_on && (dly_cnt == DLY_W'(`OWT_RSP_DLY - 1));

    // error response timer
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            dly_on  <= 1'b0;
            dly_cnt <= '0;
        end else if (dly_fire) begin
            dly_on <= 1'b0;
        end else if (i_frame_done && i_frame_bad && !dly_on) begin
            dly_on  <= 1'b1;
            dly_cnt <= DLY_W'(1);
        end else if (dly_on) begin
            dly_cnt <= dly_cnt + 1'b1;
        end
    end

    // ========================================
    // error counter
    // ========================================
    always_comb begin
        case (i_comerr_cfg[3:2])
            2'd0:    add_step = ERR_W'(`OWT_ERR_ADD_0);
            2'd1:    add_step = ERR_W'(`OWT_ERR_ADD_1);
            2'd2:    add_step = ERR_W'(`OWT_ERR_ADD_2);
            default: add_step = ERR_W'(`OWT_ERR_ADD_3);
        endcase
        case (i_comerr_cfg[1:0])
            2'd0:    sub_step = ERR_W'(`OWT_ERR_SUB_0);
            2'd1:    sub_step = ERR_W'(`OWT_ERR_SUB_1);
            2'd2:    sub_step = ERR_W'(`OWT_ERR_SUB_2);
            default: sub_step = ERR_W'(`OWT_ERR_SUB_3);
        endcase
    end

    assign err_sum = {1'b0, err_cnt} + {1'b0, add_step};

    // saturate at the ceiling and at zero
    always_comb begin
        if (dly_fire) begin
            err_nxt = (err_sum >= (ERR_W + 1)'(`OWT_ERR_MAX)) ? ERR_W'(`OWT_ERR_MAX)
                                                             : err_sum[ERR_W-1:0];
        end else begin
            err_nxt = (sub_step >= err_cnt) ? '0 : err_cnt - sub_step;
        end
    end

    assign flag_nxt = i_comerr_mode ? (err_nxt == '0) : (err_nxt >= add_step);

    // flag follows the counter only at an acknowledge
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rx_ack    <= 1'b0;
            o_rx_status <= 1'b0;
            err_cnt     <= ERR_W'(`OWT_ERR_MAX);
            o_com_err   <= 1'b1;
        end else begin
            o_rx_ack    <= ack_good || dly_fire;
            o_rx_status <= dly_fire;
            if (ack_good || dly_fire) begin
                err_cnt   <= err_nxt;
                o_com_err <= flag_nxt;
            end
        end
    end

endmodule

// File: rtl/owt_frame_rx.sv
// frame receiver
`timescale 1ns/1ps
`include "owt_macros.svh"

module owt_frame_rx (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    owt_sym_if.frame                 sym,
    output logic                     o_frame_done,
    output logic                     o_frame_bad,
    output logic [`OWT_CMD_BITS-1:0] o_cmd,
    output owt_pkg::data_u           o_data
);

    localparam int TMR_W = $clog2(`OWT_FRAME_TMO);

    owt_pkg::frame_st_e       st;
    logic [3:0]               bcnt;
    logic [3:0]               last_idx;
    logic [`OWT_CMD_BITS-1:0] cmd_sr;
    owt_pkg::data_u           data_sr;
    logic [`OWT_CRC_BITS-1:0] crc_sr;
    logic [`OWT_CRC_BITS-1:0] crc_rx;
    logic [`OWT_CRC_BITS-1:0] crc_calc;
    logic [TMR_W-1:0]         tmr;
    logic                     in_frame;
    logic                     is_adc;
    logic                     field_end;
    logic                     crc_match;
    logic                     abort;
    logic                     frame_ok;
    logic                     good_pend;

    assign sym.hunt  = (st == owt_pkg::IDLE) || (st == owt_pkg::END);
    assign in_frame  = !sym.hunt;

    // read command with the adc code carries a 12-bit sample
    assign is_adc    = !cmd_sr[`OWT_CMD_BITS-1] &&
                       (cmd_sr[`OWT_CMD_BITS-2:0] == `OWT_ADC_CODE);

    always_comb begin
        case (st)
            owt_pkg::CMD:  last_idx = 4'(`OWT_CMD_BITS - 1);
            owt_pkg::DATA: last_idx = is_adc ? 4'(`OWT_ADC_BITS - 1) : 4'(`OWT_NML_BITS - 1);
            default:       last_idx = 4'(`OWT_CRC_BITS - 1);
        endcase
    end

    assign field_end = sym.bit_vld && (bcnt == last_idx);
    assign crc_rx    = {crc_sr[`OWT_CRC_BITS-2:0], sym.bit_val};
    assign crc_match = (crc_rx == crc_calc);
    assign abort     = in_frame && (sym.sym_err || tmr == TMR_W'(`OWT_FRAME_TMO - 1));
    assign frame_ok  = (st == owt_pkg::CRC) && field_end && crc_match && !abort;

    owt_crc8 u_crc8 (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_clear   (st == owt_pkg::IDLE && sym.frame_start),
        .i_bit_vld (sym.bit_vld && (st == owt_pkg::CMD || st == owt_pkg::DATA)),
        .i_bit     (sym.bit_val),
        .o_crc     (crc_calc)
    );

    // ========================================
    // frame state machine
    // ========================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            st           <= owt_pkg::IDLE;
            bcnt         <= '0;
            tmr          <= '0;
            good_pend    <= 1'b0;
            o_frame_done <= 1'b0;
            o_frame_bad  <= 1'b0;
        end else begin
            o_frame_done <= 1'b0;
            tmr          <= in_frame ? tmr + 1'b1 : '0;
            if (abort) begin
                st           <= owt_pkg::END;
                good_pend    <= 1'b0;
                o_frame_done <= 1'b1;
                o_frame_bad  <= 1'b1;
            end else begin
                case (st)
                    owt_pkg::IDLE: begin
                        if (sym.frame_start) begin
                            st <= owt_pkg::SYNC;
                        end
                    end
                    owt_pkg::SYNC: begin
                        bcnt <= '0;
                        if (sym.sync_ok) begin
                            st <= owt_pkg::CMD;
                        end
                    end
                    owt_pkg::END: begin
                        // good frames report once the line is back low
                        if (sym.line_low) begin
                            st           <= owt_pkg::IDLE;
                            good_pend    <= 1'b0;
                            o_frame_done <= good_pend;
                        end
                    end
                    default: begin
                        if (sym.bit_vld) begin
                            bcnt <= field_end ? '0 : bcnt + 1'b1;
                        end
                        if (field_end && st == owt_pkg::CMD) begin
                            st <= owt_pkg::DATA;
                        end else if (field_end && st == owt_pkg::DATA) begin
                            st <= owt_pkg::CRC;
                        end else if (field_end) begin
                            st           <= owt_pkg::END;
                            good_pend    <= crc_match;
                            o_frame_done <= !crc_match;
                            o_frame_bad  <= !crc_match;
                        end
                    end
                endcase
            end
        end
    end

    // field shift registers
    always_ff @(posedge i_clk) begin
        if (st == owt_pkg::IDLE && sym.frame_start) begin
            data_sr <= '0;
        end else if (sym.bit_vld) begin
            case (st)
                owt_pkg::CMD: begin
                    cmd_sr <= {cmd_sr[`OWT_CMD_BITS-2:0], sym.bit_val};
                end
                owt_pkg::DATA: begin
                    if (is_adc) begin
                        data_sr.adc_s.sample <=
                            {data_sr.adc_s.sample[`OWT_ADC_BITS-2:0], sym.bit_val};
                    end else begin
                        data_sr.nml_s.value <=
                            {data_sr.nml_s.value[`OWT_NML_BITS-2:0], sym.bit_val};
                    end
                end
                owt_pkg::CRC: begin
                    crc_sr <= crc_rx;
                end
                default: begin
                end
            endcase
        end
    end

    // outputs move only on a good crc
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_cmd  <= '0;
            o_data <= '0;
        end else if (frame_ok) begin
            o_cmd  <= cmd_sr;
            o_data <= data_sr;
        end
    end

endmodule

// File: rtl/owt_crc8.sv
// serial crc8 accumulator
`timescale 1ns/1ps
`include "owt_macros.svh"

module owt_crc8 (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_clear,
    input  logic                     i_bit_vld,
    input  logic                     i_bit,
    output logic [`OWT_CRC_BITS-1:0] o_crc
);

    logic fb;

    // msb first, feedback from the top bit
    assign fb = o_crc[`OWT_CRC_BITS-1] ^ i_bit;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_crc <= '0;
        end else if (i_clear) begin
            o_crc <= '0;
        end else if (i_bit_vld) begin
            o_crc <= {o_crc[`OWT_CRC_BITS-2:0], 1'b0} ^ (fb ? `OWT_CRC_POLY : '0);
        end
    end

endmodule

// File: rtl/owt_mcst_decoder.sv
// manchester symbol decoder
`timescale 1ns/1ps
`include "owt_macros.svh"

module owt_mcst_decoder (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_line,
    owt_sym_if.decoder sym
);

    localparam logic [1:0] D_HUNT = 2'd0;
    localparam logic [1:0] D_HEAD = 2'd1;
    localparam logic [1:0] D_TAIL = 2'd2;
    localparam logic [1:0] D_BITS = 2'd3;

    logic                  line_s1;
    logic                  line_s2;
    logic                  line_d;
    logic                  edge_det;
    logic                  rise;
    owt_pkg::cyc_t         cnt;
    owt_pkg::cyc_t         avg;
    logic [`OWT_CYC_W:0]   avg_sum;
    logic [`OWT_CYC_W+1:0] lim_short;
    logic [`OWT_CYC_W+1:0] lim_long;
    logic                  is_short;
    logic                  is_long;
    logic                  bit_edge;
    logic [1:0]            st;
    logic [2:0]            head_cnt;
    logic                  tail_hi;
    logic                  mid_phase;

    // ========================================
    // synchronizer and edge timing
    // ========================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            line_s1 <= 1'b0;
            line_s2 <= 1'b0;
            line_d  <= 1'b0;
        end else begin
            line_s1 <= i_line;
            line_s2 <= line_s1;
            line_d  <= line_s2;
        end
    end

    assign edge_det     = line_s2 ^ line_d;
    assign rise         = line_s2 & ~line_d;
    assign sym.line_low = ~line_s2;

    // cycles since the previous edge, saturating
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt <= '0;
        end else if (edge_det) begin
            cnt <= owt_pkg::cyc_t'(1);
        end else if (cnt != '1) begin
            cnt <= cnt + 1'b1;
        end
    end

    // running average of T over the head
    assign avg_sum = {1'b0, avg} + {1'b0, cnt};

    always_ff @(posedge i_clk) begin
        if (st == D_HEAD && edge_det) begin
            avg <= (head_cnt == 3'd0) ? cnt : avg_sum[`OWT_CYC_W:1];
        end
    end

    // short up to 1.5T, long up to 2.5T
    assign lim_short = {2'b00, avg} + {3'b000, avg[`OWT_CYC_W-1:1]};
    assign lim_long  = {1'b0, avg, 1'b0} + {3'b000, avg[`OWT_CYC_W-1:1]};
    assign is_short  = ({2'b00, cnt} <= lim_short);
    assign is_long   = !is_short && ({2'b00, cnt} <= lim_long);
    assign bit_edge  = mid_phase ? is_long : is_short;

    // ========================================
    // sync and bit recovery
    // ========================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            st              <= D_HUNT;
            head_cnt        <= '0;
            tail_hi         <= 1'b0;
            mid_phase       <= 1'b0;
            sym.frame_start <= 1'b0;
            sym.sync_ok     <= 1'b0;
            sym.bit_vld     <= 1'b0;
            sym.bit_val     <= 1'b0;
            sym.sym_err     <= 1'b0;
        end else begin
            sym.frame_start <= 1'b0;
            sym.sync_ok     <= 1'b0;
            sym.bit_vld     <= 1'b0;
            sym.sym_err     <= 1'b0;
            // hunt lags frame_start by one cycle
            if (sym.hunt && !sym.frame_start && st != D_HUNT) begin
                st <= D_HUNT;
            end else if (edge_det) begin
                case (st)
                    D_HUNT: begin
                        if (rise) begin
                            st              <= D_HEAD;
                            head_cnt        <= '0;
                            sym.frame_start <= 1'b1;
                        end
                    end
                    D_HEAD: begin
                        head_cnt <= head_cnt + 1'b1;
                        if (head_cnt == 3'(`OWT_HEAD_EDGES - 2)) begin
                            st      <= D_TAIL;
                            tail_hi <= 1'b0;
                        end
                    end
                    D_TAIL: begin
                        // short low, then a long high ending on a mid-bit fall
                        if (!tail_hi && rise && is_short) begin
                            tail_hi <= 1'b1;
                        end else if (tail_hi && !rise && is_long) begin
                            st          <= D_BITS;
                            mid_phase   <= 1'b1;
                            sym.sync_ok <= 1'b1;
                        end else begin
                            st          <= D_HUNT;
                            sym.sym_err <= 1'b1;
                        end
                    end
                    default: begin
                        if (bit_edge) begin
                            mid_phase   <= 1'b1;
                            sym.bit_vld <= 1'b1;
                            sym.bit_val <= ~rise;
                        end else if (mid_phase && is_short) begin
                            mid_phase <= 1'b0;
                        end else begin
                            st          <= D_HUNT;
                            sym.sym_err <= 1'b1;
                        end
                    end
                endcase
            end
        end
    end

endmodule

// File: rtl/owt_sym_if.sv
// symbol decoder to frame receiver link
`timescale 1ns/1ps

interface owt_sym_if (
    input logic i_clk
);
    logic frame_start;
    logic sync_ok;
    logic bit_vld;
    logic bit_val;
    logic sym_err;
    logic line_low;
    logic hunt;

    modport decoder (
        input  i_clk, hunt,
        output frame_start, sync_ok, bit_vld, bit_val, sym_err, line_low
    );

    modport frame (
        input  i_clk, frame_start, sync_ok, bit_vld, bit_val, sym_err, line_low,
        output hunt
    );
endinterface

// File: rtl/owt_pkg.sv
// one-wire receiver types
`include "owt_macros.svh"

package owt_pkg;

    // frame receiver states
    typedef enum logic [2:0] {
        IDLE = 3'd0,
        SYNC = 3'd1,
        CMD  = 3'd2,
        DATA = 3'd3,
        CRC  = 3'd4,
        END  = 3'd5
    } frame_st_e;

    // cycles between two line edges
    typedef logic [`OWT_CYC_W-1:0] cyc_t;

    // data word, adc sample or normal byte depending on the command
    typedef union packed {
        struct packed {
            logic [`OWT_DATA_W-`OWT_ADC_BITS-1:0] pad;
            logic [`OWT_ADC_BITS-1:0]             sample;
        } adc_s;
        struct packed {
            logic [`OWT_DATA_W-`OWT_NML_BITS-1:0] pad;
            logic [`OWT_NML_BITS-1:0]             value;
        } nml_s;
    } data_u;

endpackage

// File: rtl/owt_macros.svh
// one-wire receiver constants
`ifndef OWT_MACROS_SVH
`define OWT_MACROS_SVH

// frame field lengths
`define OWT_CMD_BITS    8
`define OWT_ADC_BITS    12
`define OWT_NML_BITS    8
`define OWT_CRC_BITS    8
`define OWT_DATA_W      16
`define OWT_ADC_CODE    7'h1f
`define OWT_CRC_POLY    8'h07

// symbol timing
`define OWT_HEAD_EDGES  8
`define OWT_CYC_W       8
`define OWT_FRAME_TMO   2048
`define OWT_RSP_DLY     64

// error counter steps
`define OWT_ERR_MAX     15
`define OWT_ERR_ADD_0   1
`define OWT_ERR_ADD_1   2
`define OWT_ERR_ADD_2   4
`define OWT_ERR_ADD_3   8
`define OWT_ERR_SUB_0   1
`define OWT_ERR_SUB_1   2
`define OWT_ERR_SUB_2   3
`define OWT_ERR_SUB_3   4

`endif
